//--- dac_spi_pkg.sv
`default_nettype none

package dac_spi_pkg;

    ////////////////////////////////////////////////////////////
    // Serial frame format
    ////////////////////////////////////////////////////////////

    localparam int WORD_BITS = 24;     // Write bit, 3-bit address, 20-bit payload
    localparam int CODE_BITS = 20;     // DAC code width

    // Frame sequencing
    typedef enum logic [1:0] {
        IDLE  = 2'd0,                  // Link quiet, waiting for a pending word
        LOAD  = 2'd1,                  // Snapshot staged words
        SHIFT = 2'd2,                  // Sync low, bits going out
        GAP   = 2'd3                   // Sync back high before the next frame
    } frame_state_e;

endpackage

`default_nettype wire

//--- dac_regs_pkg.sv
`default_nettype none

package dac_regs_pkg;

    ////////////////////////////////////////////////////////////
    // AXI4-Lite register map
    ////////////////////////////////////////////////////////////

    localparam int ADDR_BITS = 8;

    localparam logic [ADDR_BITS-1:0] CH_DATA_BASE = 8'h00;  // Channel n at +4n
    localparam logic [ADDR_BITS-1:0] CFG_WORD     = 8'h10;  // Raw 24-bit word
    localparam logic [ADDR_BITS-1:0] CFG_SEND     = 8'h14;  // Channel mask
    localparam logic [ADDR_BITS-1:0] STATUS       = 8'h18;  // Busy and pending
    localparam logic [ADDR_BITS-1:0] MON_BASE     = 8'h20;  // Last sent word, +4n

    // Bus responses
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // DAC internal register addresses
    typedef enum logic [2:0] {
        REG_NOP     = 3'd0,
        REG_DATA    = 3'd1,            // DAC code register
        REG_CTRL    = 3'd2,
        REG_CLRCODE = 3'd3,
        REG_SWCTRL  = 3'd4
    } dac_reg_e;

endpackage

`default_nettype wire

//--- dac_axil_regs.sv
`timescale 1ns/10ps
`default_nettype none

module dac_axil_regs
    import dac_spi_pkg::*;
    import dac_regs_pkg::*;
#(
    parameter int NUM_DAC = 4
)
(
    input  wire                           PMD_clk,
    input  wire                           arst_n,
    input  wire  [ADDR_BITS-1:0]          awaddr,
    input  wire                           awvalid,
    output logic                          awready,
    input  wire  [31:0]                   wdata,
    input  wire  [3:0]                    wstrb,     // Full-word writes only
    input  wire                           wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  wire                           bready,
    input  wire  [ADDR_BITS-1:0]          araddr,
    input  wire                           arvalid,
    output logic                          arready,
    output logic [31:0]                   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  wire                           rready,
    input  wire  [NUM_DAC*WORD_BITS-1:0]  stage_words,
    input  wire  [NUM_DAC*WORD_BITS-1:0]  sent_words,
    input  wire                           busy,
    input  wire                           pending,
    output logic [NUM_DAC-1:0]            stage_we,
    output logic [WORD_BITS-1:0]          stage_word
);

    logic [WORD_BITS-1:0] cfg_word;
    logic                 wr_go, rd_go;
    logic                 wr_ch_hit, wr_cfg_word, wr_cfg_send, wr_ok;
    logic                 rd_ch_hit, rd_mon_hit;
    logic [1:0]           wr_idx, rd_idx;
    logic [31:0]          rd_data;
    logic                 rd_ok;

    // True for an aligned address inside a block of live channels
    function automatic logic ch_hit(input logic [ADDR_BITS-1:0] addr,
                                    input logic [ADDR_BITS-1:0] base);
        logic [ADDR_BITS-1:0] off;
        off = addr - base;
        return (addr >= base) && (off < ADDR_BITS'(4 * NUM_DAC)) && (addr[1:0] == 2'b00);
    endfunction

    ////////////////////////////////////////////////////////////
    // Write channel
    ////////////////////////////////////////////////////////////

    assign wr_go   = awvalid && wvalid && !bvalid;
    assign awready = wr_go;
    assign wready  = wr_go;

    assign wr_ch_hit   = ch_hit(awaddr, CH_DATA_BASE);
    assign wr_cfg_word = (awaddr == CFG_WORD);
    assign wr_cfg_send = (awaddr == CFG_SEND);
    assign wr_ok       = wr_ch_hit || wr_cfg_word || wr_cfg_send;  // STATUS, MON are read-only
    assign wr_idx      = awaddr[3:2];

    always_comb
    begin
        stage_we   = '0;
        stage_word = cfg_word;
        if (wr_go && wr_ch_hit)
        begin
            stage_we   = NUM_DAC'(1) << wr_idx;
            stage_word = {1'b0, REG_DATA, wdata[CODE_BITS-1:0]};  // Data register write
        end
        else if (wr_go && wr_cfg_send)
            stage_we = wdata[NUM_DAC-1:0];   // Raw word fan-out
    end

    always_ff @(posedge PMD_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bvalid   <= 1'b0;
            bresp    <= RESP_OKAY;
            cfg_word <= '0;
        end
        else
        begin
            if (wr_go)
            begin
                bvalid <= 1'b1;
                bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
                if (wr_cfg_word)
                    cfg_word <= wdata[WORD_BITS-1:0];
            end
            else if (bready)
                bvalid <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read channel
    ////////////////////////////////////////////////////////////

    assign rd_go   = arvalid && !rvalid;
    assign arready = rd_go;

    assign rd_ch_hit  = ch_hit(araddr, CH_DATA_BASE);
    assign rd_mon_hit = ch_hit(araddr, MON_BASE);
    assign rd_idx     = araddr[3:2];   // Both channel blocks sit on 16-byte boundaries

    always_comb
    begin
        rd_ok   = 1'b1;
        rd_data = '0;
        if (rd_ch_hit)
            rd_data = 32'(stage_words[rd_idx*WORD_BITS +: WORD_BITS]);
        else if (rd_mon_hit)
            rd_data = 32'(sent_words[rd_idx*WORD_BITS +: WORD_BITS]);
        else if (araddr == CFG_WORD)
            rd_data = 32'(cfg_word);
        else if (araddr == STATUS)
            rd_data = {30'd0, pending, busy};
        else
            rd_ok = 1'b0;   // Unmapped, data stays 0
    end

    always_ff @(posedge PMD_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rvalid <= 1'b0;
            rresp  <= RESP_OKAY;
            rdata  <= '0;
        end
        else if (rd_go)
        begin
            rvalid <= 1'b1;
            rresp  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            rdata  <= rd_data;
        end
        else if (rready)
            rvalid <= 1'b0;
    end

endmodule

`default_nettype wire

//--- dac_word_latch.sv
`timescale 1ns/10ps
`default_nettype none

module dac_word_latch
    import dac_spi_pkg::*;
#(
    parameter int NUM_DAC = 4
)
(
    input  wire                           PMD_clk,
    input  wire                           arst_n,
    input  wire  [NUM_DAC-1:0]            stage_we,
    input  wire  [WORD_BITS-1:0]          stage_word,
    input  wire                           frame_load,
    output logic [NUM_DAC*WORD_BITS-1:0]  stage_words,
    output logic [NUM_DAC*WORD_BITS-1:0]  sent_words,
    output logic                          pending
);

    ////////////////////////////////////////////////////////////
    // Per-channel staging and sent words
    ////////////////////////////////////////////////////////////

    for (genvar ch = 0; ch < NUM_DAC; ch++)
    begin : g_ch
        always_ff @(posedge PMD_clk or negedge arst_n)
        begin
            if (!arst_n)
            begin
                stage_words[ch*WORD_BITS +: WORD_BITS] <= '0;
                sent_words[ch*WORD_BITS +: WORD_BITS]  <= '0;
            end
            else
            begin
                if (stage_we[ch])
                    stage_words[ch*WORD_BITS +: WORD_BITS] <= stage_word;  // Later write wins
                // Snapshot of all channels at once
                if (frame_load)
                    sent_words[ch*WORD_BITS +: WORD_BITS] <= stage_words[ch*WORD_BITS +: WORD_BITS];
            end
        end
    end

    // Set by any staging write, cleared when a frame takes the snapshot
    always_ff @(posedge PMD_clk or negedge arst_n)
    begin
        if (!arst_n)
            pending <= 1'b0;
        else if (|stage_we)
            pending <= 1'b1;   // Wins over frame_load, the new word still needs a frame
        else if (frame_load)
            pending <= 1'b0;
    end

endmodule

`default_nettype wire

//--- dac_frame_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module dac_frame_ctrl
    import dac_spi_pkg::*;
#(
    parameter int DIV_HALF = 2
)
(
    input  wire   PMD_clk,
    input  wire   arst_n,
    input  wire   pending,
    output logic  frame_load,
    output logic  shift_adv,
    output logic  sclk_level,
    output logic  sync_level,
    output logic  busy
);

    localparam int DIV_W = (DIV_HALF > 1) ? $clog2(DIV_HALF) : 1;
    localparam int BIT_W = $clog2(WORD_BITS);

    frame_state_e     state;
    logic [DIV_W-1:0] div_cnt;      // Cycles within a half period
    logic             half_sel;     // Second half of a bit period
    logic [BIT_W-1:0] bit_cnt;
    logic             half_end, period_end, last_bit;

    assign half_end   = (div_cnt == DIV_W'(DIV_HALF - 1));
    assign period_end = half_end && half_sel;
    assign last_bit   = (bit_cnt == BIT_W'(WORD_BITS - 1));

    ////////////////////////////////////////////////////////////
    // Frame FSM and serial clock divider
    ////////////////////////////////////////////////////////////

    always_ff @(posedge PMD_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= IDLE;
            div_cnt  <= '0;
            half_sel <= 1'b0;
            bit_cnt  <= '0;
        end
        else
        begin
            // Divider only runs in SHIFT and GAP, back at zero on exit
            if (state == SHIFT || state == GAP)
            begin
                if (half_end)
                begin
                    div_cnt  <= '0;
                    half_sel <= ~half_sel;
                end
                else
                    div_cnt <= div_cnt + 1'b1;
            end

            case (state)
                IDLE:
                    if (pending)
                        state <= LOAD;
                LOAD:
                    state <= SHIFT;
                SHIFT:
                    if (period_end)
                    begin
                        if (last_bit)
                        begin
                            state   <= GAP;
                            bit_cnt <= '0;
                        end
                        else
                            bit_cnt <= bit_cnt + 1'b1;
                    end
                GAP:
                    if (period_end)
                        state <= IDLE;   // One full bit period of sync high
                default:
                    state <= IDLE;
            endcase
        end
    end

    assign frame_load = (state == LOAD);
    assign busy       = (state != IDLE);
    assign sync_level = (state != SHIFT);
    assign sclk_level = (state == SHIFT) && !half_sel;   // High in first half
    assign shift_adv  = (state == SHIFT) && !half_sel && (div_cnt == '0) && (bit_cnt != '0);

endmodule

`default_nettype wire

//--- dac_shift_out.sv
`timescale 1ns/10ps
`default_nettype none

module dac_shift_out
    import dac_spi_pkg::*;
#(
    parameter int NUM_DAC = 4
)
(
    input  wire                           PMD_clk,
    input  wire                           arst_n,
    input  wire  [NUM_DAC*WORD_BITS-1:0]  sent_words,
    input  wire                           frame_load,
    input  wire                           shift_adv,
    input  wire                           sclk_level,
    input  wire                           sync_level,
    output logic                          sclk,
    output logic                          sync_n,
    output logic [NUM_DAC-1:0]            sdin
);

    logic load_d;   // Snapshot is in sent_words one cycle after frame_load
    logic adv_d;

    // Pin stage, strobes delayed so data moves on the rising sclk
    always_ff @(posedge PMD_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            load_d <= 1'b0;
            adv_d  <= 1'b0;
            sclk   <= 1'b0;
            sync_n <= 1'b1;
        end
        else
        begin
            load_d <= frame_load;
            adv_d  <= shift_adv;
            sclk   <= sclk_level;
            sync_n <= sync_level;
        end
    end

    ////////////////////////////////////////////////////////////
    // One shift register per DAC, MSB first
    ////////////////////////////////////////////////////////////

    for (genvar ch = 0; ch < NUM_DAC; ch++)
    begin : g_sh
        logic [WORD_BITS-1:0] shreg;

        always_ff @(posedge PMD_clk or negedge arst_n)
        begin
            if (!arst_n)
                shreg <= '0;
            else if (load_d)
                shreg <= sent_words[ch*WORD_BITS +: WORD_BITS];
            else if (adv_d)
                shreg <= {shreg[WORD_BITS-2:0], 1'b0};
        end

        assign sdin[ch] = shreg[WORD_BITS-1];
    end

endmodule

`default_nettype wire

//--- dac_spi_top.sv
`timescale 1ns/10ps
`default_nettype none

module dac_spi_top
    import dac_spi_pkg::*;
    import dac_regs_pkg::*;
#(
    parameter int NUM_DAC  = 4,   // 1 to 4
    parameter int DIV_HALF = 2    // sclk half period in PMD_clk cycles
)
(
    input  wire                    PMD_clk,
    input  wire                    arst_n,
    input  wire  [ADDR_BITS-1:0]   awaddr,
    input  wire                    awvalid,
    output wire                    awready,
    input  wire  [31:0]            wdata,
    input  wire  [3:0]             wstrb,
    input  wire                    wvalid,
    output wire                    wready,
    output wire  [1:0]             bresp,
    output wire                    bvalid,
    input  wire                    bready,
    input  wire  [ADDR_BITS-1:0]   araddr,
    input  wire                    arvalid,
    output wire                    arready,
    output wire  [31:0]            rdata,
    output wire  [1:0]             rresp,
    output wire                    rvalid,
    input  wire                    rready,
    output wire                    sclk,
    output wire                    sync_n,
    output wire  [NUM_DAC-1:0]     sdin
);

    wire [NUM_DAC-1:0]           stage_we;
    wire [WORD_BITS-1:0]         stage_word;
    wire [NUM_DAC*WORD_BITS-1:0] stage_words;
    wire [NUM_DAC*WORD_BITS-1:0] sent_words;
    wire                         pending, busy;
    wire                         frame_load, shift_adv;
    wire                         sclk_level, sync_level;

    dac_axil_regs #(.NUM_DAC(NUM_DAC)) u_regs (
        .PMD_clk(PMD_clk), .arst_n(arst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .stage_words(stage_words), .sent_words(sent_words),
        .busy(busy), .pending(pending),
        .stage_we(stage_we), .stage_word(stage_word)
    );

    dac_word_latch #(.NUM_DAC(NUM_DAC)) u_latch (
        .PMD_clk(PMD_clk), .arst_n(arst_n),
        .stage_we(stage_we), .stage_word(stage_word), .frame_load(frame_load),
        .stage_words(stage_words), .sent_words(sent_words), .pending(pending)
    );

    dac_frame_ctrl #(.DIV_HALF(DIV_HALF)) u_ctrl (
        .PMD_clk(PMD_clk), .arst_n(arst_n), .pending(pending),
        .frame_load(frame_load), .shift_adv(shift_adv),
        .sclk_level(sclk_level), .sync_level(sync_level), .busy(busy)
    );

    dac_shift_out #(.NUM_DAC(NUM_DAC)) u_shift (
        .PMD_clk(PMD_clk), .arst_n(arst_n), .sent_words(sent_words),
        .frame_load(frame_load), .shift_adv(shift_adv),
        .sclk_level(sclk_level), .sync_level(sync_level),
        .sclk(sclk), .sync_n(sync_n), .sdin(sdin)
    );

endmodule

`default_nettype wire

//--- dac_spi_sva.sv
`timescale 1ns/10ps
`default_nettype none

module dac_spi_sva
(
    input wire PMD_clk,
    input wire arst_n,
    input wire sclk,
    input wire sync_n,
    input wire bvalid,
    input wire bready,
    input wire rvalid,
    input wire rready
);

    int fail_count = 0;   // Failed assertion attempts

    // Frame opens only from a low sclk
    a_sync_fall: assert property (@(posedge PMD_clk) disable iff (!arst_n)
        $fell(sync_n) |-> !$past(sclk))
        else
        begin
            $error("sync_n fell while sclk was high");
            fail_count++;
        end

    a_sclk_idle: assert property (@(posedge PMD_clk) disable iff (!arst_n)
        sync_n |-> !sclk)
        else
        begin
            $error("sclk high outside a frame");
            fail_count++;
        end

    ////////////////////////////////////////////////////////////
    // AXI4-Lite response channels
    ////////////////////////////////////////////////////////////

    a_bvalid_hold: assert property (@(posedge PMD_clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid)
        else
        begin
            $error("bvalid dropped before bready");
            fail_count++;
        end

    a_rvalid_hold: assert property (@(posedge PMD_clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid)
        else
        begin
            $error("rvalid dropped before rready");
            fail_count++;
        end

endmodule

bind dac_spi_top dac_spi_sva u_sva (
    .PMD_clk(PMD_clk),
    .arst_n(arst_n),
    .sclk(sclk),
    .sync_n(sync_n),
    .bvalid(bvalid),
    .bready(bready),
    .rvalid(rvalid),
    .rready(rready)
);

`default_nettype wire

//--- tb_dac_spi.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dac_spi
    import dac_spi_pkg::*;
    import dac_regs_pkg::*;
();

    localparam int NUM_DAC       = 4;
    localparam int DIV_HALF      = 2;
    localparam int SHIFT_CYCLES  = WORD_BITS * 2 * DIV_HALF;   // sync_n low time
    localparam int CYCLES_PER_OP = 200;

    logic                 PMD_clk, arst_n;
    logic [ADDR_BITS-1:0] awaddr, araddr;
    logic                 awvalid, awready, wvalid, wready, bvalid, bready;
    logic [31:0]          wdata, rdata;
    logic [3:0]           wstrb;
    logic [1:0]           bresp, rresp;
    logic                 arvalid, arready, rvalid, rready;
    logic                 sclk, sync_n;
    logic [NUM_DAC-1:0]   sdin;

    // One entry per stimulus line
    logic [7:0]  op_q[$];
    logic [31:0] addr_q[$], data_q[$], exp_q[$];

    logic [WORD_BITS-1:0] stage_model [NUM_DAC];   // What each channel should send next
    logic [WORD_BITS-1:0] cfg_model;
    logic [WORD_BITS-1:0] frame_words [NUM_DAC];
    logic [WORD_BITS-1:0] last_words  [NUM_DAC];
    int                   errors, frames_done, frames_checked;
    int                   bit_count, low_cycles, cycles, cycle_limit;
    int                   aw_accepts, w_accepts, ar_accepts;
    logic                 sclk_prev, sync_prev;

    dac_spi_top #(.NUM_DAC(NUM_DAC), .DIV_HALF(DIV_HALF)) dut (.*);

    always #50 PMD_clk = ~PMD_clk;

    ////////////////////////////////////////////////////////////
    // Frame monitor sampled mid-cycle
    ////////////////////////////////////////////////////////////

    always @(negedge PMD_clk)
    begin
        if (!arst_n)
        begin
            sclk_prev = 1'b0;
            sync_prev = 1'b1;
        end
        else
        begin
            if (sync_prev && !sync_n)
            begin
                bit_count  = 0;   // New frame
                low_cycles = 0;
            end
            if (!sync_n)
            begin
                low_cycles++;
                if (sclk_prev && !sclk)   // DAC latches on the falling sclk
                begin
                    bit_count++;
                    for (int ch = 0; ch < NUM_DAC; ch++)
                        frame_words[ch] = {frame_words[ch][WORD_BITS-2:0], sdin[ch]};
                end
            end
            else if (!sync_prev)
            begin
                if (bit_count != WORD_BITS)
                begin
                    $display("Frame had %0d falling sclk edges instead of %0d",
                             bit_count, WORD_BITS);
                    errors++;
                end
                if (low_cycles != SHIFT_CYCLES)
                begin
                    $display("sync_n was low for %0d cycles instead of %0d",
                             low_cycles, SHIFT_CYCLES);
                    errors++;
                end
                last_words = frame_words;
                frames_done++;
            end
            sclk_prev = sclk;
            sync_prev = sync_n;
        end
    end

    // Address and data handshakes taken at the clock edge
    always @(posedge PMD_clk)
    begin
        if (awvalid && awready)
            aw_accepts++;
        if (wvalid && wready)
            w_accepts++;
        if (arvalid && arready)
            ar_accepts++;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus file and bus tasks
    ////////////////////////////////////////////////////////////

    task automatic load_stim();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] a, d, e;
        fd = $fopen("dac_stim.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file dac_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#")   // Skip blank and comment lines
            begin
                n = $sscanf(line, "%c %h %h %h", op, a, d, e);
                if (n == 4)
                begin
                    op_q.push_back(op);
                    addr_q.push_back(a);
                    data_q.push_back(d);
                    exp_q.push_back(e);
                end
                else
                begin
                    $display("Stimulus line could not be parsed: %s", line);
                    errors++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int aw_before;
        int w_before;
        aw_before = aw_accepts;
        w_before  = w_accepts;
        @(negedge PMD_clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge PMD_clk);
        while (!bvalid)
            @(negedge PMD_clk);
        resp    = bresp;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge PMD_clk);   // One cycle of back-pressure on bvalid
        bready = 1'b1;
        @(negedge PMD_clk);
        bready = 1'b0;
        if (aw_accepts - aw_before != 1 || w_accepts - w_before != 1)
        begin
            $display("Error: awready/wready pulses at 0x%02h are 0x%0h/0x%0h, expected 0x1",
                     addr, aw_accepts - aw_before, w_accepts - w_before);
            errors++;
        end
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int ar_before;
        ar_before = ar_accepts;
        @(negedge PMD_clk);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge PMD_clk);
        while (!rvalid)
            @(negedge PMD_clk);
        data    = rdata;
        resp    = rresp;
        arvalid = 1'b0;
        @(negedge PMD_clk);   // One cycle of back-pressure on rvalid
        rready = 1'b1;
        @(negedge PMD_clk);
        rready = 1'b0;
        if (ar_accepts - ar_before != 1)
        begin
            $display("Error: arready pulses at 0x%02h are 0x%0h, expected 0x1",
                     addr, ar_accepts - ar_before);
            errors++;
        end
    endtask

    // Staged word per channel from the register map rules
    function automatic void update_model(input logic [7:0] addr, input logic [31:0] data);
        if (addr < 8'(4 * NUM_DAC) && addr[1:0] == 2'b00)
            stage_model[addr[3:2]] = {1'b0, 3'b001, data[19:0]};   // Write, DAC data reg, code
        else if (addr == CFG_WORD)
            cfg_model = data[WORD_BITS-1:0];
        else if (addr == CFG_SEND)
            for (int ch = 0; ch < NUM_DAC; ch++)
                if (data[ch])
                    stage_model[ch] = cfg_model;
    endfunction

    task automatic check_frames(input int count);
        int          target;
        logic [1:0]  resp;
        logic [31:0] status;
        target = frames_checked + count;
        wait (frames_done >= target);
        do
            axi_read(STATUS, status, resp);
        while (status[1:0] != 2'b00);   // Wait for an idle link with nothing left to send
        if (frames_done != target)
        begin
            $display("Expected %0d frames but saw %0d", count, frames_done - frames_checked);
            errors++;
        end
        for (int ch = 0; ch < NUM_DAC; ch++)
            if (last_words[ch] !== stage_model[ch])
            begin
                $display("Error: sdin[%0d] word is 0x%06h, expected 0x%06h",
                         ch, last_words[ch], stage_model[ch]);
                errors++;
            end
        frames_checked = frames_done;
    endtask

    task automatic run_op(input logic [7:0] op, input logic [31:0] a,
                          input logic [31:0] d, input logic [31:0] e);
        logic [1:0]  resp;
        logic [31:0] data;
        case (op)
            "W":
            begin
                axi_write(a[7:0], d, resp);
                update_model(a[7:0], d);
                if (resp !== e[1:0])
                begin
                    $display("Error: bresp at 0x%02h is 0x%0h, expected 0x%0h", a, resp, e);
                    errors++;
                end
            end
            "R":
            begin
                axi_read(a[7:0], data, resp);
                if (resp !== e[1:0])
                begin
                    $display("Error: rresp at 0x%02h is 0x%0h, expected 0x%0h", a, resp, e);
                    errors++;
                end
                if (data !== d)
                begin
                    $display("Error: rdata at 0x%02h is 0x%08h, expected 0x%08h", a, data, d);
                    errors++;
                end
            end
            "F":
                check_frames(int'(e));
            default:
            begin
                $display("Unknown operation in the stimulus file");
                errors++;
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial
    begin : watchdog
        wait (cycle_limit != 0);
        while (cycles < cycle_limit)
        begin
            @(posedge PMD_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
        $display("Finished: %0d frames, %0d errors", frames_done, errors);
        $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin : main
        PMD_clk        = 1'b0;
        arst_n         = 1'b1;
        awaddr         = '0;
        awvalid        = 1'b0;
        wdata          = '0;
        wstrb          = 4'hf;
        wvalid         = 1'b0;
        bready         = 1'b0;
        araddr         = '0;
        arvalid        = 1'b0;
        rready         = 1'b0;
        errors         = 0;
        frames_done    = 0;
        frames_checked = 0;
        cycles         = 0;
        cycle_limit    = 0;
        aw_accepts     = 0;
        w_accepts      = 0;
        ar_accepts     = 0;
        cfg_model      = '0;
        for (int ch = 0; ch < NUM_DAC; ch++)
        begin
            stage_model[ch] = '0;
            frame_words[ch] = '0;
            last_words[ch]  = '0;
        end
        load_stim();
        cycle_limit = (op_q.size() + 1) * CYCLES_PER_OP;   // Extra slot covers reset

        @(negedge PMD_clk);
        arst_n = 1'b0;
        repeat (10)
            @(negedge PMD_clk);
        arst_n = 1'b1;
        @(negedge PMD_clk);
        if (sync_n !== 1'b1)
        begin
            $display("Error: sync_n after reset is 0x%0h, expected 0x1", sync_n);
            errors++;
        end
        if (sclk !== 1'b0)
        begin
            $display("Error: sclk after reset is 0x%0h, expected 0x0", sclk);
            errors++;
        end

        for (int i = 0; i < op_q.size(); i++)
            run_op(op_q[i], addr_q[i], data_q[i], exp_q[i]);

        if (dut.u_sva.fail_count != 0)
        begin
            $display("%0d protocol assertions failed", dut.u_sva.fail_count);
            errors += dut.u_sva.fail_count;
        end
        $display("Finished: %0d frames, %0d errors", frames_done, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- dac_stim.txt
# op addr data expect, hex after the op letter
# W: expect is bresp. R: data is the expected rdata, expect is rresp. F: expect is frames
R 18 0 0
R 20 0 0
R 24 0 0
R 28 0 0
R 2c 0 0
W 00 12345 0
F 0 0 1
R 20 112345 0
R 00 112345 0
W 10 abcdef 0
W 14 a 0
F 0 0 1
R 24 abcdef 0
R 28 0 0
R 2c abcdef 0
R 20 112345 0
W 04 11111 0
W 04 22222 0
W 04 33333 0
F 0 0 2
R 24 133333 0
R 04 133333 0
R 10 abcdef 0
R 40 0 2
W 40 5 2
R 34 0 2
W 34 1 2
R 18 0 0

//--- verilog.f
dac_spi_pkg.sv
dac_regs_pkg.sv
dac_axil_regs.sv
dac_word_latch.sv
dac_frame_ctrl.sv
dac_shift_out.sv
dac_spi_top.sv
dac_spi_sva.sv
tb_dac_spi.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DAC serial testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_dac_spi \
    -f verilog.f -Mdir obj_dir -o tb_dac_spi
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_dac_spi +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi
echo "Simulation passed"
exit 0
